// File: include/pic_defs.svh
`ifndef PIC_DEFS_SVH
`define PIC_DEFS_SVH

// ============================================================
// address map
// ============================================================

// controller block, only address bits 31..12 are decoded
`define PIC_BASE_ADDR 32'hFF95_0000

// request lines, line 0 is the nmi line
`define PIC_NUM_IRQ 32

// register byte offsets inside the block
`define PIC_REG_CAUSE     8'h00
`define PIC_REG_IE        8'h04
`define PIC_REG_IE_CLR    8'h08
`define PIC_REG_IE_SET    8'h0C
`define PIC_REG_ES        8'h10
`define PIC_REG_EDGE_CLR  8'h14
`define PIC_REG_TRIG      8'h18
// one control word per line from here up to 0xFC
`define PIC_REG_CTRL_BASE 8'h80

// ============================================================
// reset values
// ============================================================

`define PIC_RST_IE     32'h0000_0000
`define PIC_RST_ES     32'hFFFF_FFFF
`define PIC_RST_LEVEL  4'h8
`define PIC_RST_CAUSE  8'h00
`define PIC_RST_THREAD 4'h0

`endif

// File: hdl/pic_bus_pkg.sv
package pic_bus_pkg;

	// one bus cycle as seen by the controller
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        wr;
		logic [31:0] adr;
		logic [31:0] dat;
	} pic_bus_req_t;

	// decoded register write
	// every strobe is high for a single cycle only
	typedef struct packed {
		logic        ie_word;
		logic        ie_bit;
		// new value of the enable bit for ie_bit
		logic        ie_val;
		logic        es_word;
		logic        edge_clr;
		logic        trig;
		logic        ctrl_wr;
		// target line, from data for single-bit ops, from address for ctrl words
		logic [4:0]  line;
		logic [31:0] data;
	} pic_wr_cmd_t;

endpackage

// File: hdl/pic_irq_pkg.sv
package pic_irq_pkg;

	// ============================================================
	// per-line control word, listed from bit 31 down to bit 0
	// ============================================================
	typedef struct packed {
		// 31..24 always read as zero
		logic [7:0] rsvd_hi;
		// 23..20 target thread map
		logic [3:0] thread;
		logic [1:0] rsvd_mid;
		// 17 edge sensitivity of the line
		logic       edge_sel;
		// 16 line enable
		logic       enable;
		logic [3:0] rsvd_lo;
		// 11..8 priority level driven to the cpu
		logic [3:0] level;
		// 7..0 cause code
		logic [7:0] cause;
	} pic_irq_ctrl_t;

	// bus view and field view of the same control word
	typedef union packed {
		logic [31:0]   raw;
		pic_irq_ctrl_t ctrl;
	} pic_ctrl_word_u;

	// request as presented to the processor
	typedef struct packed {
		logic [3:0] level;
		logic [3:0] thread;
		logic [7:0] cause;
		logic       nmi;
	} pic_irq_out_t;

endpackage

// File: hdl/pic_bus_fsm.sv
`timescale 1ns/1ps
`include "pic_defs.svh"

module pic_bus_fsm
(
	input  logic                      clk,
	input  logic                      rst_i,
	input  pic_bus_pkg::pic_bus_req_t bus_i,
	output logic                      ack_o,
	output logic                      vol_o,
	output logic                      rd_o,
	output logic [5:0]                reg_ofs_o,
	output pic_bus_pkg::pic_wr_cmd_t  cmd_o
);

	localparam logic [31:0] BASE_ADDR = `PIC_BASE_ADDR;

	typedef enum logic {IDLE, RD_WAIT} state_t;

	state_t     state_q;
	state_t     state_d;
	logic       cs;
	logic       wr_sel;
	logic [7:0] byte_ofs;

	// block select, the lower 12 address bits stay inside the block
	assign cs = bus_i.cyc && bus_i.stb && (bus_i.adr[31:12] == BASE_ADDR[31:12]);
	assign vol_o = cs;
	assign wr_sel = cs && bus_i.wr;
	assign rd_o = cs && !bus_i.wr;

	// word offset for the read mux
	assign reg_ofs_o = bus_i.adr[7:2];
	assign byte_ofs = {bus_i.adr[7:2], 2'b00};

	// ============================================================
	// read wait state
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst_i)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:
				if (rd_o)
					state_d = RD_WAIT;
			// data went out this cycle, or the master dropped stb
			RD_WAIT:
				state_d = IDLE;
			default:
				state_d = IDLE;
		endcase
	end

	// writes ack at once, reads after the wait cycle
	assign ack_o = wr_sel || (rd_o && state_q == RD_WAIT);

	// ============================================================
	// write decode into one-cycle strobes
	// ============================================================
	always_comb
	begin
		cmd_o = '0;
		cmd_o.data = bus_i.dat;
		// single-bit registers name the line in the low data bits
		cmd_o.line = bus_i.dat[4:0];
		if (wr_sel)
		begin
			if (byte_ofs >= `PIC_REG_CTRL_BASE)
			begin
				// control words are indexed by address
				cmd_o.ctrl_wr = 1'b1;
				cmd_o.line = bus_i.adr[6:2];
			end
			else
			begin
				case (byte_ofs)
					`PIC_REG_IE:       cmd_o.ie_word = 1'b1;
					`PIC_REG_IE_CLR,
					`PIC_REG_IE_SET:
					begin
						// 0x08 clears, 0x0C sets
						cmd_o.ie_bit = 1'b1;
						cmd_o.ie_val = bus_i.adr[2];
					end
					`PIC_REG_ES:       cmd_o.es_word = 1'b1;
					`PIC_REG_EDGE_CLR: cmd_o.edge_clr = 1'b1;
					`PIC_REG_TRIG:     cmd_o.trig = 1'b1;
					// cause register and holes ignore writes
					default: ;
				endcase
			end
		end
	end

	// an ack needs select now, and for reads also in the cycle before
	a_ack_cs: assert property (@(posedge clk) disable iff (rst_i)
		$rose(ack_o) |-> cs && (bus_i.wr || $past(rd_o)));

endmodule

// File: hdl/pic_edge_prio.sv
`timescale 1ns/1ps
`include "pic_defs.svh"

module pic_edge_prio
(
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic [31:1]              irq_i,
	input  logic [31:0]              es_i,
	input  pic_bus_pkg::pic_wr_cmd_t cmd_i,
	output logic [4:0]               irq_num_o
);

	// previous input sample for edge detect
	logic [31:1] samp_q;
	// sticky edge latches
	logic [31:1] edge_q;
	// request per line, bit 0 is the nmi line and stays low
	logic [31:0] pending;
	logic [4:0]  enc;

	always_ff @(posedge clk)
		samp_q <= irq_i;

	// ============================================================
	// edge latches
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst_i)
			edge_q <= '0;
		else
		begin
			for (int n = 1; n < `PIC_NUM_IRQ; n++)
			begin
				// clear beats a set landing in the same cycle
				if (cmd_i.edge_clr && (cmd_i.line == 5'(n)))
					edge_q[n] <= 1'b0;
				else if ((irq_i[n] && !samp_q[n]) || (cmd_i.trig && (cmd_i.line == 5'(n))))
					edge_q[n] <= 1'b1;
			end
		end
	end

	// edge lines use the latch, level lines the raw input
	always_comb
	begin
		pending = '0;
		for (int n = 1; n < `PIC_NUM_IRQ; n++)
			pending[n] = es_i[n] ? edge_q[n] : irq_i[n];
	end

	// ============================================================
	// priority encoder
	// ============================================================
	always_comb
	begin
		enc = 5'd0;
		// ascending scan, so the highest pending line is kept
		for (int n = 1; n < `PIC_NUM_IRQ; n++)
		begin
			if (pending[n])
				enc = 5'(n);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			irq_num_o <= 5'd0;
		else
			irq_num_o <= enc;
	end

	// a reported line was pending one cycle earlier
	a_num_pending: assert property (@(posedge clk) disable iff (rst_i)
		(irq_num_o != 5'd0) |-> ((($past(pending) >> irq_num_o) & 32'd1) != 32'd0));

endmodule

// File: hdl/pic_vector_table.sv
`timescale 1ns/1ps
`include "pic_defs.svh"

module pic_vector_table
(
	input  logic                      clk,
	input  logic                      rst_i,
	input  pic_bus_pkg::pic_wr_cmd_t  cmd_i,
	input  logic                      rd_i,
	input  logic [5:0]                reg_ofs_i,
	input  logic [4:0]                irq_num_i,
	output logic [31:0]               es_o,
	output logic [31:0]               dat_o,
	output pic_irq_pkg::pic_irq_out_t irq_o,
	input  logic                      nmi_i
);
	import pic_irq_pkg::*;

	// enable and edge-select words, bit n belongs to line n
	logic [31:0]    ie_q;
	logic [31:0]    es_q;
	// control table fields that live only here
	logic [3:0]     level_q  [`PIC_NUM_IRQ];
	logic [7:0]     cause_q  [`PIC_NUM_IRQ];
	logic [3:0]     thread_q [`PIC_NUM_IRQ];
	pic_ctrl_word_u wr_word;
	pic_ctrl_word_u rd_word;
	logic [4:0]     rd_line;
	logic [7:0]     rd_byte_ofs;
	logic [31:0]    rd_mux;
	logic [31:0]    dat_q;

	// unpack the incoming control word
	always_comb
		wr_word.raw = cmd_i.data;

	// ============================================================
	// enable and edge-select words
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			ie_q <= `PIC_RST_IE;
			es_q <= `PIC_RST_ES;
		end
		else
		begin
			if (cmd_i.ie_word)
				ie_q <= cmd_i.data;
			if (cmd_i.ie_bit)
				ie_q[cmd_i.line] <= cmd_i.ie_val;
			if (cmd_i.es_word)
				es_q <= cmd_i.data;
			// a control word also carries its line's enable and edge bits
			if (cmd_i.ctrl_wr)
			begin
				ie_q[cmd_i.line] <= wr_word.ctrl.enable;
				es_q[cmd_i.line] <= wr_word.ctrl.edge_sel;
			end
		end
	end

	assign es_o = es_q;

	// per-line level, cause and thread
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int n = 0; n < `PIC_NUM_IRQ; n++)
			begin
				level_q[n]  <= `PIC_RST_LEVEL;
				cause_q[n]  <= `PIC_RST_CAUSE;
				thread_q[n] <= `PIC_RST_THREAD;
			end
		end
		else if (cmd_i.ctrl_wr)
		begin
			level_q[cmd_i.line]  <= wr_word.ctrl.level;
			cause_q[cmd_i.line]  <= wr_word.ctrl.cause;
			thread_q[cmd_i.line] <= wr_word.ctrl.thread;
		end
	end

	// ============================================================
	// read path
	// ============================================================
	assign rd_line = reg_ofs_i[4:0];
	assign rd_byte_ofs = {reg_ofs_i, 2'b00};

	always_comb
	begin
		// pack one table entry, reserved bits stay zero
		rd_word = '0;
		rd_word.ctrl.cause = cause_q[rd_line];
		rd_word.ctrl.level = level_q[rd_line];
		rd_word.ctrl.thread = thread_q[rd_line];
		rd_word.ctrl.enable = ie_q[rd_line];
		rd_word.ctrl.edge_sel = es_q[rd_line];
		if (rd_byte_ofs >= `PIC_REG_CTRL_BASE)
			rd_mux = rd_word.raw;
		else if (rd_byte_ofs == `PIC_REG_CAUSE)
			rd_mux = {24'd0, cause_q[irq_num_i]};
		else
			rd_mux = ie_q;
	end

	// data captured in the select cycle, shown in the ack cycle
	always_ff @(posedge clk)
	begin
		if (rd_i)
			dat_q <= rd_mux;
	end

	// bus sees zero while the block is not selected
	assign dat_o = rd_i ? dat_q : 32'd0;

	// ============================================================
	// processor outputs
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst_i)
			irq_o <= '0;
		else
		begin
			irq_o.nmi <= nmi_i & ie_q[0];
			if (irq_num_i == 5'd0)
			begin
				irq_o.level  <= 4'd0;
				irq_o.thread <= 4'd0;
				irq_o.cause  <= 8'd0;
			end
			else
			begin
				// a disabled winner still shows its cause
				irq_o.level  <= level_q[irq_num_i] & {4{ie_q[irq_num_i]}};
				irq_o.thread <= thread_q[irq_num_i] & {4{ie_q[irq_num_i]}};
				irq_o.cause  <= cause_q[irq_num_i];
			end
		end
	end

	// a level reaches the cpu only from an enabled winner of the previous cycle
	a_level_en: assert property (@(posedge clk) disable iff (rst_i)
		(irq_o.level != 4'd0) |-> $past(ie_q[irq_num_i] && (irq_num_i != 5'd0)));

endmodule

// File: hdl/pic_top.sv
`timescale 1ns/1ps

module pic_top
(
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      cyc_i,
	input  logic                      stb_i,
	input  logic                      wr_i,
	input  logic [31:0]               adr_i,
	input  logic [31:0]               dat_i,
	output logic                      ack_o,
	output logic [31:0]               dat_o,
	output logic                      vol_o,
	input  logic [31:1]               irq_i,
	input  logic                      nmi_i,
	output pic_irq_pkg::pic_irq_out_t irq_o
);
	import pic_bus_pkg::*;

	pic_bus_req_t bus;
	pic_wr_cmd_t  cmd;
	logic         rd;
	logic [5:0]   reg_ofs;
	// edge-select word from the table to the edge logic
	logic [31:0]  es;
	// winning line back to the table
	logic [4:0]   irq_num;

	// bundle the bus pins
	assign bus = '{cyc: cyc_i, stb: stb_i, wr: wr_i, adr: adr_i, dat: dat_i};

	// ============================================================
	// bus side
	// ============================================================
	pic_bus_fsm i_pic_bus_fsm
	(
		.clk       (clk),
		.rst_i     (rst_i),
		.bus_i     (bus),
		.ack_o     (ack_o),
		.vol_o     (vol_o),
		.rd_o      (rd),
		.reg_ofs_o (reg_ofs),
		.cmd_o     (cmd)
	);

	// registers, read mux and cpu outputs
	pic_vector_table i_pic_vector_table
	(
		.clk       (clk),
		.rst_i     (rst_i),
		.cmd_i     (cmd),
		.rd_i      (rd),
		.reg_ofs_i (reg_ofs),
		.irq_num_i (irq_num),
		.es_o      (es),
		.dat_o     (dat_o),
		.irq_o     (irq_o),
		.nmi_i     (nmi_i)
	);

	// request side
	pic_edge_prio i_pic_edge_prio
	(
		.clk       (clk),
		.rst_i     (rst_i),
		.irq_i     (irq_i),
		.es_i      (es),
		.cmd_i     (cmd),
		.irq_num_o (irq_num)
	);

endmodule

// File: tests/tb_pic.sv
`timescale 1ns/1ps
`include "pic_defs.svh"

module tb_pic;
	import pic_irq_pkg::*;

	localparam logic [31:0] BASE = `PIC_BASE_ADDR;
	// the stimulus below runs for about 260 cycles
	localparam int MAX_CYCLES = 2000;

	logic         clk;
	logic         rst_i;
	logic         cyc_i;
	logic         stb_i;
	logic         wr_i;
	logic [31:0]  adr_i;
	logic [31:0]  dat_i;
	logic         ack_o;
	logic [31:0]  dat_o;
	logic         vol_o;
	logic [31:1]  irq_i;
	logic         nmi_i;
	pic_irq_out_t irq_o;

	// register model with bit n of a word belonging to line n
	logic [31:0]  ie_m;
	logic [31:0]  es_m;
	logic [31:0]  edge_m;
	logic [31:0]  lines;
	logic [3:0]   lvl_m   [32];
	logic [7:0]   cause_m [32];
	logic [3:0]   thr_m   [32];
	pic_irq_out_t exp_irq;
	int           exp_win;
	logic [31:0]  exp_rd;
	// one-cycle markers that start an output check
	logic         level_go;
	logic         edge_go;
	logic         hold_go;
	// ack as seen at the last rising edge
	logic         ack_seen;
	logic [31:0]  rng;
	logic         in_blk;
	logic         sel;
	logic         wr_sel;
	logic         rd_sel;
	int           errors = 0;
	int           cycles = 0;

	pic_top i_pic_top
	(
		.clk   (clk),
		.rst_i (rst_i),
		.cyc_i (cyc_i),
		.stb_i (stb_i),
		.wr_i  (wr_i),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.ack_o (ack_o),
		.dat_o (dat_o),
		.vol_o (vol_o),
		.irq_i (irq_i),
		.nmi_i (nmi_i),
		.irq_o (irq_o)
	);

	// select as the bus master sees it
	assign in_blk = (adr_i[31:12] == BASE[31:12]);
	assign sel = cyc_i && stb_i && in_blk;
	assign wr_sel = sel && wr_i;
	assign rd_sel = sel && !wr_i;

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	always @(posedge clk)
		ack_seen <= ack_o;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, %0d errors", cycles, errors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ============================================================
	// helpers
	// ============================================================
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] ctrl_ofs(input int n);
		return 8'(`PIC_REG_CTRL_BASE + 4 * n);
	endfunction

	// control word layout with the reserved bits reading as zero
	function automatic logic [31:0] ctrl_word(input int n);
		return {8'd0, thr_m[n], 2'b00, es_m[n], ie_m[n], 4'd0, lvl_m[n], cause_m[n]};
	endfunction

	task automatic flag_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("[ERROR] %s got %08h expected %08h", name, got, exp);
		errors++;
	endtask

	task automatic note_failure(input string what);
		$display("failure: %s", what);
		errors++;
	endtask

	// highest pending line wins and edge lines use their latch
	task automatic update_expect();
		logic [31:0] pend;
		int          win;
		pend = '0;
		win = 0;
		for (int n = 1; n < 32; n++)
		begin
			pend[n] = es_m[n] ? edge_m[n] : lines[n];
			if (pend[n])
				win = n;
		end
		exp_win = win;
		exp_irq = '0;
		if (win != 0)
		begin
			// cause shows even when the winner is disabled
			exp_irq.cause = cause_m[win];
			if (ie_m[win])
			begin
				exp_irq.level = lvl_m[win];
				exp_irq.thread = thr_m[win];
			end
		end
	endtask

	task automatic apply_write(input logic [7:0] ofs, input logic [31:0] data);
		int n;
		n = ofs[6:2];
		if (ofs >= `PIC_REG_CTRL_BASE)
		begin
			cause_m[n] = data[7:0];
			lvl_m[n] = data[11:8];
			ie_m[n] = data[16];
			es_m[n] = data[17];
			thr_m[n] = data[23:20];
		end
		else
		begin
			case (ofs)
				`PIC_REG_IE:       ie_m = data;
				`PIC_REG_IE_CLR:   ie_m[data[4:0]] = 1'b0;
				`PIC_REG_IE_SET:   ie_m[data[4:0]] = 1'b1;
				`PIC_REG_ES:       es_m = data;
				`PIC_REG_EDGE_CLR: edge_m[data[4:0]] = 1'b0;
				`PIC_REG_TRIG:     edge_m[data[4:0]] = 1'b1;
				default: ;
			endcase
		end
	endtask

	// called just after a falling edge and returns on the edge that sees ack
	task automatic wait_for_ack(output logic got);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!ack_seen && waited < 8)
		begin
			@(negedge clk);
			waited++;
		end
		got = ack_seen;
	endtask

	task automatic write_reg(input logic [7:0] ofs, input logic [31:0] data,
		input logic edge_chk);
		logic got;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		wr_i = 1'b1;
		adr_i = BASE | {24'd0, ofs};
		dat_i = data;
		edge_go = edge_chk;
		wait_for_ack(got);
		if (!got)
			note_failure($sformatf("no acknowledge for write to offset %02h", ofs));
		cyc_i = 1'b0;
		stb_i = 1'b0;
		wr_i = 1'b0;
		edge_go = 1'b0;
		apply_write(ofs, data);
		update_expect();
		@(negedge clk);
	endtask

	task automatic read_reg(input logic [7:0] ofs, input logic [31:0] expected);
		logic got;
		exp_rd = expected;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		wr_i = 1'b0;
		adr_i = BASE | {24'd0, ofs};
		wait_for_ack(got);
		if (!got)
			note_failure($sformatf("no acknowledge for read of offset %02h", ofs));
		cyc_i = 1'b0;
		stb_i = 1'b0;
		@(negedge clk);
	endtask

	// access one block above the controller where nothing may answer
	task automatic probe_outside(input logic wr);
		cyc_i = 1'b1;
		stb_i = 1'b1;
		wr_i = wr;
		adr_i = BASE + 32'h0000_1000;
		repeat (2) @(negedge clk);
		cyc_i = 1'b0;
		stb_i = 1'b0;
		wr_i = 1'b0;
		@(negedge clk);
	endtask

	task automatic drive_lines(input logic [31:0] value, input logic lvl_chk,
		input logic edge_chk);
		// any rising line sets its latch whatever its mode
		edge_m = edge_m | (value & ~lines);
		lines = {value[31:1], 1'b0};
		irq_i = value[31:1];
		level_go = lvl_chk;
		edge_go = edge_chk;
		update_expect();
		@(negedge clk);
		level_go = 1'b0;
		edge_go = 1'b0;
	endtask

	task automatic check_outputs();
		hold_go = 1'b1;
		@(negedge clk);
		hold_go = 1'b0;
	endtask

	task automatic settle();
		repeat (4) @(negedge clk);
	endtask

	// ============================================================
	// checks
	// ============================================================
	a_wr_ack: assert property (@(posedge clk) disable iff (rst_i) wr_sel |-> ack_o)
		else note_failure("write not acknowledged in its select cycle");
	a_rd_ack: assert property (@(posedge clk) disable iff (rst_i)
		$rose(rd_sel) |-> !ack_o ##1 ack_o)
		else note_failure("read not acknowledged exactly one cycle after select");
	a_no_ack: assert property (@(posedge clk) disable iff (rst_i) !sel |-> !ack_o)
		else note_failure("acknowledge without chip select");
	a_vol: assert property (@(posedge clk) disable iff (rst_i) vol_o == sel)
		else flag_value("vol_o", $sampled(vol_o), $sampled(sel));
	a_rd_dat: assert property (@(posedge clk) disable iff (rst_i)
		(rd_sel && ack_o) |-> dat_o == exp_rd)
		else flag_value("dat_o", $sampled(dat_o), $sampled(exp_rd));
	a_dat_idle: assert property (@(posedge clk) disable iff (rst_i) !sel |-> dat_o == 32'd0)
		else flag_value("dat_o", $sampled(dat_o), 32'd0);
	a_nmi: assert property (@(posedge clk) disable iff (rst_i)
		irq_o.nmi == $past(nmi_i & ie_m[0]))
		else flag_value("irq_o.nmi", $sampled(irq_o.nmi), $past(nmi_i & ie_m[0]));
	// level lines take two cycles and edges and triggers three
	a_level: assert property (@(posedge clk) disable iff (rst_i)
		level_go |-> ##2 (irq_o[16:1] == exp_irq[16:1]))
		else flag_value("irq_o", $sampled(irq_o), $sampled(exp_irq));
	a_edge: assert property (@(posedge clk) disable iff (rst_i)
		edge_go |-> ##3 (irq_o[16:1] == exp_irq[16:1]))
		else flag_value("irq_o", $sampled(irq_o), $sampled(exp_irq));
	a_hold: assert property (@(posedge clk) disable iff (rst_i)
		hold_go |-> (irq_o[16:1] == exp_irq[16:1]))
		else flag_value("irq_o", $sampled(irq_o), $sampled(exp_irq));

	// ============================================================
	// stimulus
	// ============================================================
	initial
	begin
		logic [4:0]  line;
		logic [31:0] hit;
		rst_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		wr_i = 1'b0;
		adr_i = 32'd0;
		dat_i = 32'd0;
		irq_i = '0;
		nmi_i = 1'b0;
		level_go = 1'b0;
		edge_go = 1'b0;
		hold_go = 1'b0;
		exp_rd = 32'd0;
		rng = 32'd49059;
		ie_m = `PIC_RST_IE;
		es_m = `PIC_RST_ES;
		edge_m = '0;
		lines = '0;
		for (int n = 0; n < 32; n++)
		begin
			lvl_m[n] = `PIC_RST_LEVEL;
			cause_m[n] = `PIC_RST_CAUSE;
			thr_m[n] = `PIC_RST_THREAD;
		end
		update_expect();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		// reset values of outputs, enable word and table
		check_outputs();
		read_reg(`PIC_REG_IE, ie_m);
		for (int n = 0; n < 32; n++)
			read_reg(ctrl_ofs(n), ctrl_word(n));

		probe_outside(1'b1);
		probe_outside(1'b0);

		// random control words read back through the table
		for (int k = 0; k < 8; k++)
		begin
			rng = xorshift(rng);
			line = rng[4:0];
			rng = xorshift(rng);
			write_reg(ctrl_ofs(line), rng, 1'b0);
			read_reg(ctrl_ofs(line), ctrl_word(line));
		end
		rng = xorshift(rng);
		write_reg(`PIC_REG_IE, rng, 1'b0);
		read_reg(`PIC_REG_IE, ie_m);
		rng = xorshift(rng);
		write_reg(`PIC_REG_IE_CLR, {27'd0, rng[4:0]}, 1'b0);
		read_reg(`PIC_REG_IE, ie_m);
		write_reg(`PIC_REG_IE_SET, {27'd0, rng[9:5]}, 1'b0);
		read_reg(`PIC_REG_IE, ie_m);
		rng = xorshift(rng);
		write_reg(`PIC_REG_ES, rng, 1'b0);
		read_reg(ctrl_ofs(rng[4:0]), ctrl_word(rng[4:0]));
		read_reg(ctrl_ofs(rng[9:5]), ctrl_word(rng[9:5]));

		// level priority among three enabled lines
		write_reg(`PIC_REG_ES, 32'd0, 1'b0);
		write_reg(`PIC_REG_IE, 32'd0, 1'b0);
		hit = (32'd1 << 5) | (32'd1 << 12) | (32'd1 << 20);
		for (int n = 0; n < 32; n++)
		begin
			rng = xorshift(rng);
			if (hit[n])
				write_reg(ctrl_ofs(n), (rng & 32'h00F0_0FFF) | 32'h0011_0101, 1'b0);
		end
		drive_lines(hit, 1'b1, 1'b0);
		settle();
		// with the winner disabled its cause stays visible
		write_reg(`PIC_REG_IE_CLR, 32'd20, 1'b0);
		settle();
		check_outputs();
		read_reg(`PIC_REG_CAUSE, {24'd0, cause_m[exp_win]});
		drive_lines(32'd0, 1'b1, 1'b0);
		settle();
		check_outputs();

		// edge latch on a one-cycle pulse
		rng = xorshift(rng);
		write_reg(ctrl_ofs(9), (rng & 32'h00F0_0FFF) | 32'h0003_0100, 1'b0);
		write_reg(`PIC_REG_EDGE_CLR, 32'd9, 1'b0);
		drive_lines(32'd1 << 9, 1'b0, 1'b1);
		drive_lines(32'd0, 1'b0, 1'b0);
		settle();
		check_outputs();
		write_reg(`PIC_REG_EDGE_CLR, 32'd9, 1'b0);
		settle();
		check_outputs();

		// software trigger with quiet inputs
		rng = xorshift(rng);
		write_reg(ctrl_ofs(27), (rng & 32'h00F0_0FFF) | 32'h0003_0100, 1'b0);
		write_reg(`PIC_REG_TRIG, 32'd27, 1'b1);
		settle();
		check_outputs();
		write_reg(`PIC_REG_EDGE_CLR, 32'd27, 1'b0);
		settle();
		check_outputs();

		// nmi passes only while enable bit 0 is set
		write_reg(`PIC_REG_IE_SET, 32'd0, 1'b0);
		nmi_i = 1'b1;
		repeat (3) @(negedge clk);
		nmi_i = 1'b0;
		settle();
		write_reg(`PIC_REG_IE_CLR, 32'd0, 1'b0);
		nmi_i = 1'b1;
		repeat (3) @(negedge clk);
		nmi_i = 1'b0;
		settle();

		$display("run complete after %0d cycles, %0d errors", cycles, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: build.f
+incdir+include
hdl/pic_bus_pkg.sv
hdl/pic_irq_pkg.sv
hdl/pic_bus_fsm.sv
hdl/pic_edge_prio.sv
hdl/pic_vector_table.sv
hdl/pic_top.sv
tests/tb_pic.sv

// File: Bender.yml
package:
  name: pic

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/pic_bus_pkg.sv
      - hdl/pic_irq_pkg.sv
      - hdl/pic_bus_fsm.sv
      - hdl/pic_edge_prio.sv
      - hdl/pic_vector_table.sv
      - hdl/pic_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_pic.sv
